// ==== host_domain_config.svh ====
/*
 * Host-domain configuration port constants
 * Bus widths, window placement, mailbox register map and error pattern
 */

`ifndef HOST_DOMAIN_CONFIG_SVH
`define HOST_DOMAIN_CONFIG_SVH

`define HD_ADDR_W 32
`define HD_DATA_W 32

// Configuration window
`define HD_CFG_BASE 32'h1040_0000
`define HD_CFG_SIZE 32'h0000_1000
`define HD_MBOX_END (`HD_CFG_BASE + 32'h0000_0014)

// Mailbox register map in byte offsets of 32-bit words
`define HD_REG_DOORBELL   32'h00
`define HD_REG_COMPLETION 32'h04
`define HD_REG_SCRATCH0   32'h08
`define HD_REG_SCRATCH1   32'h0c
`define HD_REG_EVT_COUNT  32'h10

`define HD_ERR_PATTERN 32'hdeadf000
`define HD_EVT_CNT_W   16

`endif

// ==== host_domain_pkg.sv ====
/*
 * Host-domain configuration types
 * Request, decoded operation and response payloads plus the address rules
 */

`include "host_domain_config.svh"

package host_domain_pkg;

  typedef logic [`HD_ADDR_W-1:0] addr_t;
  typedef logic [`HD_DATA_W-1:0] data_t;

  // Enough bits to index every word of the mailbox range
  localparam int unsigned RegIdxW = $clog2((`HD_MBOX_END - `HD_CFG_BASE) / 4);
  typedef logic [RegIdxW-1:0] reg_idx_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef struct packed {
    addr_t addr;
  } cfg_rd_req_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
  } cfg_wr_req_t;

  typedef struct packed {
    logic     write;
    logic     hit;
    reg_idx_t reg_idx;
    data_t    wdata;
  } cfg_op_t;

  typedef struct packed {
    data_t     data;
    axi_resp_e resp;
  } cfg_rd_rsp_t;

  typedef struct packed {
    axi_resp_e resp;
  } cfg_wr_rsp_t;

  typedef struct packed {
    int unsigned idx;
    addr_t       start_addr;
    addr_t       end_addr;
  } rule_t;

  // End address is exclusive
  localparam int unsigned NumRules = 1;
  localparam rule_t cfg_rules [NumRules] = '{
    '{idx: 0, start_addr: `HD_CFG_BASE, end_addr: `HD_MBOX_END}
  };

endpackage

// ==== host_evt_sync.sv ====
/*
 * Edge-propagator receiver
 * Synchronizes a toggling event and emits one pulse per toggle
 */

`timescale 1ns/10ps

module host_evt_sync (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  logic sync0_q;
  logic sync1_q;
  logic hist_q;

  // Two-flop synchronizer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync0_q <= 1'b0;
      sync1_q <= 1'b0;
    end else begin
      sync0_q <= valid_i;
      sync1_q <= sync0_q;
    end
  end

  // Previous synchronized level
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hist_q <= 1'b0;
    end else begin
      hist_q <= sync1_q;
    end
  end

  assign valid_o = sync1_q ^ hist_q;

  // Sender sees its own level come back
  assign ack_o = sync1_q;

endmodule

// ==== host_resp_hold.sv ====
/*
 * Response holding register
 * Keeps a response valid and stable until the master takes it
 */

`timescale 1ns/10ps

module host_resp_hold #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     load_i,
  input  payload_t payload_i,
  input  logic     ready_i,
  output logic     valid_o,
  output payload_t payload_o,
  output logic     free_o
);

  logic     valid_q;
  payload_t payload_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (load_i) begin
      valid_q <= 1'b1;
    end else if (valid_q && ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      payload_q <= payload_i;
    end
  end

  assign valid_o   = valid_q;
  assign payload_o = payload_q;
  assign free_o    = ~valid_q;

endmodule

// ==== host_cfg_decode.sv ====
/*
 * Configuration request decoder
 * Accepts read and write requests and maps their address onto a mailbox word
 */

`timescale 1ns/10ps

`include "host_domain_config.svh"

module host_cfg_decode (
  input  logic                        rd_valid_i,
  input  host_domain_pkg::cfg_rd_req_t rd_req_i,
  input  logic                        rd_free_i,
  output logic                        rd_ready_o,
  output host_domain_pkg::cfg_op_t    rd_op_o,
  output logic                        rd_op_valid_o,
  input  logic                        wr_valid_i,
  input  host_domain_pkg::cfg_wr_req_t wr_req_i,
  input  logic                        wr_free_i,
  output logic                        wr_ready_o,
  output host_domain_pkg::cfg_op_t    wr_op_o,
  output logic                        wr_op_valid_o
);

  import host_domain_pkg::*;

  function automatic cfg_op_t decode_op(addr_t addr, logic write, data_t wdata);
    cfg_op_t op;
    addr_t   offset;
    logic    in_window;
    op        = '0;
    op.write  = write;
    op.wdata  = wdata;
    in_window = (addr >= `HD_CFG_BASE) && (addr - `HD_CFG_BASE < `HD_CFG_SIZE);
    for (int unsigned i = 0; i < NumRules; i++) begin
      if (in_window && addr >= cfg_rules[i].start_addr && addr < cfg_rules[i].end_addr) begin
        offset     = addr - cfg_rules[i].start_addr;
        op.hit     = 1'b1;
        op.reg_idx = offset[RegIdxW+1:2];
      end
    end
    return op;
  endfunction

  // One request in flight per direction
  assign rd_ready_o = rd_free_i;
  assign wr_ready_o = wr_free_i;

  assign rd_op_valid_o = rd_valid_i & rd_free_i;
  assign wr_op_valid_o = wr_valid_i & wr_free_i;

  always_comb begin
    rd_op_o = '0;
    if (rd_op_valid_o) begin
      rd_op_o = decode_op(rd_req_i.addr, 1'b0, '0);
    end
  end

  always_comb begin
    wr_op_o = '0;
    if (wr_op_valid_o) begin
      wr_op_o = decode_op(wr_req_i.addr, 1'b1, wr_req_i.data);
    end
  end

endmodule

// ==== host_mbox_regs.sv ====
/*
 * Mailbox register block
 * Doorbell, completion, two scratch words and the cluster DMA event count
 */

`timescale 1ns/10ps

`include "host_domain_config.svh"

module host_mbox_regs (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  host_domain_pkg::cfg_op_t     rd_op_i,
  input  logic                         rd_op_valid_i,
  input  host_domain_pkg::cfg_op_t     wr_op_i,
  input  logic                         wr_op_valid_i,
  input  logic                         evt_pulse_i,
  output host_domain_pkg::cfg_rd_rsp_t rd_rsp_o,
  output host_domain_pkg::cfg_wr_rsp_t wr_rsp_o,
  output logic                         doorbell_irq_o,
  output logic                         completion_irq_o
);

  import host_domain_pkg::*;

  localparam reg_idx_t IdxDoorbell   = reg_idx_t'(`HD_REG_DOORBELL >> 2);
  localparam reg_idx_t IdxCompletion = reg_idx_t'(`HD_REG_COMPLETION >> 2);
  localparam reg_idx_t IdxScratch0   = reg_idx_t'(`HD_REG_SCRATCH0 >> 2);
  localparam reg_idx_t IdxScratch1   = reg_idx_t'(`HD_REG_SCRATCH1 >> 2);
  localparam reg_idx_t IdxEvtCount   = reg_idx_t'(`HD_REG_EVT_COUNT >> 2);

  data_t                    doorbell_q;
  data_t                    completion_q;
  data_t                    scratch0_q;
  data_t                    scratch1_q;
  logic [`HD_EVT_CNT_W-1:0] evt_cnt_q;
  logic                     wr_en;
  logic                     evt_clr;

  assign wr_en   = wr_op_valid_i & wr_op_i.hit & wr_op_i.write;
  assign evt_clr = wr_en && (wr_op_i.reg_idx == IdxEvtCount);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      doorbell_q   <= '0;
      completion_q <= '0;
      scratch0_q   <= '0;
      scratch1_q   <= '0;
    end else if (wr_en) begin
      case (wr_op_i.reg_idx)
        IdxDoorbell:   doorbell_q   <= wr_op_i.wdata;
        IdxCompletion: completion_q <= wr_op_i.wdata;
        IdxScratch0:   scratch0_q   <= wr_op_i.wdata;
        IdxScratch1:   scratch1_q   <= wr_op_i.wdata;
        default: ;
      endcase
    end
  end

  // Clear wins over a pulse, but the pulse still counts
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      evt_cnt_q <= '0;
    end else if (evt_clr) begin
      evt_cnt_q <= evt_pulse_i ? `HD_EVT_CNT_W'(1) : '0;
    end else if (evt_pulse_i) begin
      evt_cnt_q <= evt_cnt_q + 1'b1;
    end
  end

  // Read payload from current register state
  always_comb begin
    rd_rsp_o.data = '0;
    rd_rsp_o.resp = RESP_OKAY;
    if (rd_op_valid_i) begin
      if (!rd_op_i.hit) begin
        rd_rsp_o.data = `HD_ERR_PATTERN;
        rd_rsp_o.resp = RESP_DECERR;
      end else begin
        case (rd_op_i.reg_idx)
          IdxDoorbell:   rd_rsp_o.data = doorbell_q;
          IdxCompletion: rd_rsp_o.data = completion_q;
          IdxScratch0:   rd_rsp_o.data = scratch0_q;
          IdxScratch1:   rd_rsp_o.data = scratch1_q;
          IdxEvtCount:   rd_rsp_o.data = data_t'(evt_cnt_q);
          default: begin
            rd_rsp_o.data = `HD_ERR_PATTERN;
            rd_rsp_o.resp = RESP_DECERR;
          end
        endcase
      end
    end
  end

  assign wr_rsp_o.resp = (wr_op_valid_i && !wr_op_i.hit) ? RESP_DECERR : RESP_OKAY;

  // Level interrupts
  assign doorbell_irq_o   = |doorbell_q;
  assign completion_irq_o = |completion_q;

endmodule

// ==== host_domain.sv ====
/*
 * Host-domain configuration port
 * Register target with mailbox interrupts and a cluster DMA event counter
 */

`timescale 1ns/10ps

module host_domain (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Read channel
  input  host_domain_pkg::cfg_rd_req_t rd_req_i,
  input  logic                         rd_valid_i,
  output logic                         rd_ready_o,
  output host_domain_pkg::cfg_rd_rsp_t rd_rsp_o,
  output logic                         rd_rsp_valid_o,
  input  logic                         rd_rsp_ready_i,
  // Write channel
  input  host_domain_pkg::cfg_wr_req_t wr_req_i,
  input  logic                         wr_valid_i,
  output logic                         wr_ready_o,
  output host_domain_pkg::cfg_wr_rsp_t wr_rsp_o,
  output logic                         wr_rsp_valid_o,
  input  logic                         wr_rsp_ready_i,
  // Cluster DMA event
  input  logic                         dma_pe_evt_valid_i,
  output logic                         dma_pe_evt_ack_o,
  output logic                         doorbell_irq_o,
  output logic                         completion_irq_o
);

  import host_domain_pkg::*;

  cfg_op_t     rd_op;
  cfg_op_t     wr_op;
  logic        rd_op_valid;
  logic        wr_op_valid;
  cfg_rd_rsp_t rd_rsp_d;
  cfg_wr_rsp_t wr_rsp_d;
  logic        rd_free;
  logic        wr_free;
  logic        evt_pulse;

  host_cfg_decode u_decode (
    .rd_valid_i    ( rd_valid_i  ),
    .rd_req_i      ( rd_req_i    ),
    .rd_free_i     ( rd_free     ),
    .rd_ready_o    ( rd_ready_o  ),
    .rd_op_o       ( rd_op       ),
    .rd_op_valid_o ( rd_op_valid ),
    .wr_valid_i    ( wr_valid_i  ),
    .wr_req_i      ( wr_req_i    ),
    .wr_free_i     ( wr_free     ),
    .wr_ready_o    ( wr_ready_o  ),
    .wr_op_o       ( wr_op       ),
    .wr_op_valid_o ( wr_op_valid )
  );

  host_mbox_regs u_mbox_regs (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .rd_op_i          ( rd_op            ),
    .rd_op_valid_i    ( rd_op_valid      ),
    .wr_op_i          ( wr_op            ),
    .wr_op_valid_i    ( wr_op_valid      ),
    .evt_pulse_i      ( evt_pulse        ),
    .rd_rsp_o         ( rd_rsp_d         ),
    .wr_rsp_o         ( wr_rsp_d         ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o )
  );

  host_evt_sync u_evt_sync (
    .clk_i   ( clk_i              ),
    .rst_n_i ( rst_n_i            ),
    .valid_i ( dma_pe_evt_valid_i ),
    .valid_o ( evt_pulse          ),
    .ack_o   ( dma_pe_evt_ack_o   )
  );

  host_resp_hold #(
    .payload_t ( cfg_rd_rsp_t )
  ) u_rd_hold (
    .clk_i     ( clk_i          ),
    .rst_n_i   ( rst_n_i        ),
    .load_i    ( rd_op_valid    ),
    .payload_i ( rd_rsp_d       ),
    .ready_i   ( rd_rsp_ready_i ),
    .valid_o   ( rd_rsp_valid_o ),
    .payload_o ( rd_rsp_o       ),
    .free_o    ( rd_free        )
  );

  host_resp_hold #(
    .payload_t ( cfg_wr_rsp_t )
  ) u_wr_hold (
    .clk_i     ( clk_i          ),
    .rst_n_i   ( rst_n_i        ),
    .load_i    ( wr_op_valid    ),
    .payload_i ( wr_rsp_d       ),
    .ready_i   ( wr_rsp_ready_i ),
    .valid_o   ( wr_rsp_valid_o ),
    .payload_o ( wr_rsp_o       ),
    .free_o    ( wr_free        )
  );

endmodule

// ==== host_domain_assertions.sv ====
/*
 * Handshake and interrupt properties for the host-domain port
 */

`timescale 1ns/10ps

module host_domain_assertions (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         rd_valid_i,
  input logic                         rd_ready_o,
  input host_domain_pkg::cfg_rd_rsp_t rd_rsp_o,
  input logic                         rd_rsp_valid_o,
  input logic                         rd_rsp_ready_i,
  input logic                         wr_valid_i,
  input logic                         wr_ready_o,
  input host_domain_pkg::cfg_wr_rsp_t wr_rsp_o,
  input logic                         wr_rsp_valid_o,
  input logic                         wr_rsp_ready_i,
  input logic                         doorbell_irq_o,
  input logic                         completion_irq_o
);

  // Response follows acceptance by one cycle
  rd_rsp_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_valid_i && rd_ready_o |=> rd_rsp_valid_o)
    else $error("read response not valid after acceptance");

  wr_rsp_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_valid_i && wr_ready_o |=> wr_rsp_valid_o)
    else $error("write response not valid after acceptance");

  // Held response keeps its payload
  rd_rsp_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_rsp_valid_o && !rd_rsp_ready_i |=> rd_rsp_valid_o && $stable(rd_rsp_o))
    else $error("read response dropped or changed while held");

  wr_rsp_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_rsp_valid_o && !wr_rsp_ready_i |=> wr_rsp_valid_o && $stable(wr_rsp_o))
    else $error("write response dropped or changed while held");

  // A response only appears after an accepted request
  rd_rsp_needs_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(rd_rsp_valid_o) |-> $past(rd_valid_i && rd_ready_o))
    else $error("read response raised without an accepted request");

  wr_rsp_needs_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(wr_rsp_valid_o) |-> $past(wr_valid_i && wr_ready_o))
    else $error("write response raised without an accepted request");

  irq_low_after_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !doorbell_irq_o && !completion_irq_o && !rd_rsp_valid_o && !wr_rsp_valid_o)
    else $error("interrupt or response valid set after reset");

endmodule

// ==== tb_host_domain.sv ====
/*
 * Testbench for the host-domain configuration port
 * Directed tests of registers, interrupts, decode errors and DMA events
 */

`timescale 1ns/10ps

`include "host_domain_config.svh"

module tb_host_domain;

  import host_domain_pkg::*;

  // Tests take about 500 cycles
  localparam int unsigned TimeoutCycles = 2000;

  logic        clk_i;
  logic        rst_n_i;
  cfg_rd_req_t rd_req_i;
  logic        rd_valid_i;
  logic        rd_ready_o;
  cfg_rd_rsp_t rd_rsp_o;
  logic        rd_rsp_valid_o;
  logic        rd_rsp_ready_i;
  cfg_wr_req_t wr_req_i;
  logic        wr_valid_i;
  logic        wr_ready_o;
  cfg_wr_rsp_t wr_rsp_o;
  logic        wr_rsp_valid_o;
  logic        wr_rsp_ready_i;
  logic        dma_pe_evt_valid_i;
  logic        dma_pe_evt_ack_o;
  logic        doorbell_irq_o;
  logic        completion_irq_o;

  // Expected register contents, indexed by word offset
  logic [31:0] shadow [5];
  logic [31:0] lfsr_q;
  int unsigned error_count;
  int unsigned check_count;
  int unsigned cycle_count;

  host_domain u_host_domain (.*);

  bind host_domain host_domain_assertions u_host_domain_sva (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic random_bits(input int unsigned width, output logic [31:0] value);
    value = '0;
    for (int unsigned i = 0; i < width; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = {value[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_irqs();
    check_value("doorbell_irq_o", doorbell_irq_o, |shadow[0]);
    check_value("completion_irq_o", completion_irq_o, |shadow[1]);
  endtask

  task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data,
                           input axi_resp_e exp_resp);
    int unsigned idx;
    @(negedge clk_i);
    wr_req_i.addr = addr;
    wr_req_i.data = data;
    wr_valid_i    = 1'b1;
    while (!wr_ready_o) @(negedge clk_i);
    // Handshake completes at the next rising edge
    @(negedge clk_i);
    wr_valid_i = 1'b0;
    check_value("write response valid", wr_rsp_valid_o, 1'b1);
    check_value("write response code", wr_rsp_o.resp, exp_resp);
    if (exp_resp == RESP_OKAY) begin
      idx = (addr - `HD_CFG_BASE) >> 2;
      shadow[idx] = (addr == `HD_CFG_BASE + `HD_REG_EVT_COUNT) ? '0 : data;
    end
  endtask

  task automatic cfg_read(input logic [31:0] addr, input logic [31:0] exp_data,
                          input axi_resp_e exp_resp, input int unsigned hold);
    @(negedge clk_i);
    rd_req_i.addr  = addr;
    rd_valid_i     = 1'b1;
    rd_rsp_ready_i = (hold == 0);
    while (!rd_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    rd_valid_i = 1'b0;
    check_value("read response valid", rd_rsp_valid_o, 1'b1);
    check_value("read data", rd_rsp_o.data, exp_data);
    check_value("read response code", rd_rsp_o.resp, exp_resp);
    for (int unsigned i = 0; i < hold; i++) begin
      @(negedge clk_i);
      check_value("held read valid", rd_rsp_valid_o, 1'b1);
      check_value("held read data", rd_rsp_o.data, exp_data);
      check_value("rd_ready_o while held", rd_ready_o, 1'b0);
    end
    rd_rsp_ready_i = 1'b1;
  endtask

  task automatic test_reset_state();
    @(negedge clk_i);
    check_irqs();
    check_value("rd_ready_o after reset", rd_ready_o, 1'b1);
    check_value("wr_ready_o after reset", wr_ready_o, 1'b1);
    check_value("dma_pe_evt_ack_o after reset", dma_pe_evt_ack_o, 1'b0);
    for (int unsigned i = 0; i < 5; i++) begin
      cfg_read(`HD_CFG_BASE + i * 4, 32'h0, RESP_OKAY, 0);
    end
  endtask

  task automatic test_scratch();
    logic [31:0] data;
    random_bits(32, data);
    cfg_write(`HD_CFG_BASE + `HD_REG_SCRATCH0, data, RESP_OKAY);
    random_bits(32, data);
    cfg_write(`HD_CFG_BASE + `HD_REG_SCRATCH1, data, RESP_OKAY);
    cfg_read(`HD_CFG_BASE + `HD_REG_SCRATCH0, shadow[2], RESP_OKAY, 0);
    cfg_read(`HD_CFG_BASE + `HD_REG_SCRATCH1, shadow[3], RESP_OKAY, 5);
  endtask

  task automatic test_interrupts();
    logic [31:0] data;
    for (int unsigned i = 0; i < 2; i++) begin
      random_bits(32, data);
      cfg_write(`HD_CFG_BASE + i * 4, data | 32'h1, RESP_OKAY);
      check_irqs();
      cfg_write(`HD_CFG_BASE + i * 4, 32'h0, RESP_OKAY);
      check_irqs();
    end
  endtask

  task automatic test_decode_errors();
    logic [31:0] bad_addr [4];
    logic [31:0] data;
    bad_addr = '{`HD_MBOX_END, `HD_CFG_BASE + 32'hffc,
                 `HD_CFG_BASE + `HD_CFG_SIZE, `HD_CFG_BASE - 32'h4};
    for (int unsigned i = 0; i < 4; i++) begin
      random_bits(32, data);
      cfg_write(bad_addr[i], data, RESP_DECERR);
      cfg_read(bad_addr[i], `HD_ERR_PATTERN, RESP_DECERR, 0);
    end
    for (int unsigned i = 0; i < 5; i++) begin
      cfg_read(`HD_CFG_BASE + i * 4, shadow[i], RESP_OKAY, 0);
    end
    check_irqs();
  endtask

  task automatic test_events();
    logic [31:0] num_evts;
    random_bits(3, num_evts);
    num_evts = num_evts + 2;
    cfg_write(`HD_CFG_BASE + `HD_REG_EVT_COUNT, 32'h0, RESP_OKAY);
    for (int unsigned i = 0; i < num_evts; i++) begin
      @(negedge clk_i);
      dma_pe_evt_valid_i = ~dma_pe_evt_valid_i;
      repeat (3) @(negedge clk_i);
      check_value("dma_pe_evt_ack_o", dma_pe_evt_ack_o, dma_pe_evt_valid_i);
      repeat (3) @(negedge clk_i);
    end
    cfg_read(`HD_CFG_BASE + `HD_REG_EVT_COUNT, num_evts, RESP_OKAY, 0);
    cfg_write(`HD_CFG_BASE + `HD_REG_EVT_COUNT, 32'hffff_ffff, RESP_OKAY);
    cfg_read(`HD_CFG_BASE + `HD_REG_EVT_COUNT, 32'h0, RESP_OKAY, 0);
  endtask

  initial begin
    rst_n_i            = 1'b0;
    rd_req_i           = '0;
    rd_valid_i         = 1'b0;
    rd_rsp_ready_i     = 1'b1;
    wr_req_i           = '0;
    wr_valid_i         = 1'b0;
    wr_rsp_ready_i     = 1'b1;
    dma_pe_evt_valid_i = 1'b0;
    lfsr_q             = 32'h74f2;
    error_count        = 0;
    check_count        = 0;
    for (int i = 0; i < 5; i++) begin
      shadow[i] = '0;
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    test_reset_state();
    test_scratch();
    test_interrupts();
    test_decode_errors();
    test_events();
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: tests did not finish within %0d cycles", TimeoutCycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== host_domain.f ====
+incdir+.
host_domain_pkg.sv
host_evt_sync.sv
host_resp_hold.sv
host_cfg_decode.sv
host_mbox_regs.sv
host_domain.sv
host_domain_assertions.sv
tb_host_domain.sv

// ==== Bender.yml ====
package:
  name: host_domain

export_include_dirs:
  - .

sources:
  - host_domain_pkg.sv
  - host_evt_sync.sv
  - host_resp_hold.sv
  - host_cfg_decode.sv
  - host_mbox_regs.sv
  - host_domain.sv
  - target: test
    files:
      - host_domain_assertions.sv
      - tb_host_domain.sv
